/* logic/soc_mem_pkg.sv */
// Memory subsystem package.
// AXI4-Lite channel structs, response and decode enums, and the region map
// shared by the router, the RAMs and the top level.
package soc_mem_pkg;

  localparam int ADDR_W = 32;         // Byte address width.
  localparam int DATA_W = 32;         // One bus word per beat.
  localparam int STRB_W = DATA_W / 8; // One strobe bit per byte lane.

  localparam logic [15:0] REGION_CODE = 16'h0000; // Upper half-word of the code RAM.
  localparam logic [15:0] REGION_DATA = 16'h8000; // Upper half-word of the data RAM.

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } axil_resp_e;

  // Result of the address decode in the router.
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_CODE,
    TGT_DATA
  } mem_target_e;

  typedef struct packed {
    logic [ADDR_W-1:0] awaddr;
    logic              awvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              wvalid;
    logic              bready;
    logic [ADDR_W-1:0] araddr;
    logic              arvalid;
    logic              rready;
  } axil_req_t;

  typedef struct packed {
    logic              awready;
    logic              wready;
    axil_resp_e        bresp;
    logic              bvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    axil_resp_e        rresp;
    logic              rvalid;
  } axil_rsp_t;

  typedef struct packed {
    logic sw_irq;
    logic timer_irq;
    logic ext_irq;
  } irq_t;

endpackage

/* logic/axil_ram.sv */
`timescale 1ns/1ps
// AXI4-Lite word RAM with byte strobes.
// Holds one read and one write response at a time. After reset the array
// is swept to zero, one word per cycle, before any request is taken.
module axil_ram #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                   clk,
  input  logic                   rst,
  input  soc_mem_pkg::axil_req_t req_i,
  output soc_mem_pkg::axil_rsp_t rsp_o
);
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [soc_mem_pkg::DATA_W-1:0] mem_array [MEM_WORDS];

  logic                           clr_busy_ff;
  logic [IDX_W-1:0]               clr_idx_ff;
  logic                           rvalid_ff;
  logic [soc_mem_pkg::DATA_W-1:0] rdata_ff;
  logic                           bvalid_ff;

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic             rd_fire;
  logic             wr_fire;
  logic             rd_done;
  logic             wr_done;

  always_comb begin
    rd_idx  = req_i.araddr[IDX_W+1:2]; // Index wraps at the RAM depth.
    wr_idx  = req_i.awaddr[IDX_W+1:2];
    rd_fire = req_i.arvalid && !rvalid_ff && !clr_busy_ff;
    wr_fire = req_i.awvalid && req_i.wvalid && !bvalid_ff && !clr_busy_ff;
    rd_done = rvalid_ff && req_i.rready;
    wr_done = bvalid_ff && req_i.bready;
  end

  // Clear sweep walks every word once after reset.
  always_ff @(posedge clk) begin
    if (!rst) begin
      clr_busy_ff <= 1'b1;
      clr_idx_ff  <= '0;
    end else if (clr_busy_ff) begin
      clr_idx_ff <= clr_idx_ff + 1'b1;
      if (clr_idx_ff == IDX_W'(MEM_WORDS - 1)) begin
        clr_busy_ff <= 1'b0; // Last word cleared.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clr_busy_ff) begin
      mem_array[clr_idx_ff] <= '0;
    end else if (wr_fire) begin
      for (int b = 0; b < soc_mem_pkg::STRB_W; b++) begin
        if (req_i.wstrb[b]) begin
          mem_array[wr_idx][8*b +: 8] <= req_i.wdata[8*b +: 8]; // Only strobed lanes.
        end
      end
    end
  end

  // Same-word write in this cycle is not visible here yet.
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_ff <= mem_array[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      rvalid_ff <= 1'b0;
      bvalid_ff <= 1'b0;
    end else begin
      if (rd_fire) begin
        rvalid_ff <= 1'b1;
      end else if (rd_done) begin
        rvalid_ff <= 1'b0;
      end
      if (wr_fire) begin
        bvalid_ff <= 1'b1;
      end else if (wr_done) begin
        bvalid_ff <= 1'b0;
      end
    end
  end

  always_comb begin
    rsp_o.arready = !rvalid_ff && !clr_busy_ff;
    rsp_o.rvalid  = rvalid_ff;
    rsp_o.rdata   = rdata_ff;
    rsp_o.rresp   = soc_mem_pkg::OKAY;
    rsp_o.awready = wr_fire; // AW and W complete together.
    rsp_o.wready  = wr_fire;
    rsp_o.bvalid  = bvalid_ff;
    rsp_o.bresp   = soc_mem_pkg::OKAY;
  end

  // A stalled read response keeps its data until the master takes it.
  a_rvalid_hold: assert property (
    @(posedge clk) disable iff (!rst)
    rvalid_ff && !req_i.rready |=> rvalid_ff && $stable(rdata_ff)
  );

  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (!rst)
    bvalid_ff && !req_i.bready |=> bvalid_ff
  );

endmodule

/* logic/axil_addr_router.sv */
`timescale 1ns/1ps
// AXI4-Lite address router for the code and data RAMs.
// Steers each request to one RAM by address, answers unmapped addresses
// with DECERR and merges the responses back onto the target port.
module axil_addr_router #(
  parameter int CODE_WORDS = 1024,
  parameter int DATA_WORDS = 2048
) (
  input  logic                   clk,
  input  logic                   rst,
  input  soc_mem_pkg::axil_req_t s_req_i,
  output soc_mem_pkg::axil_rsp_t s_rsp_o,
  output soc_mem_pkg::axil_req_t code_req_o,
  input  soc_mem_pkg::axil_rsp_t code_rsp_i,
  output soc_mem_pkg::axil_req_t data_req_o,
  input  soc_mem_pkg::axil_rsp_t data_rsp_i
);
  soc_mem_pkg::mem_target_e rd_tgt;
  soc_mem_pkg::mem_target_e wr_tgt;
  soc_mem_pkg::mem_target_e rd_tgt_ff;
  soc_mem_pkg::mem_target_e wr_tgt_ff;

  logic       rd_pend_ff;
  logic       wr_pend_ff;
  logic [1:0] ram_up_ff;
  logic       err_ok;
  logic       ar_ready;
  logic       aw_ready;
  logic       rd_hs;
  logic       wr_hs;
  logic       rd_done;
  logic       wr_done;

  function automatic soc_mem_pkg::mem_target_e decode_addr(
    input logic [soc_mem_pkg::ADDR_W-1:0] addr
  );
    int word_idx;
    word_idx = int'(addr[15:2]);
    if (addr[31:16] == soc_mem_pkg::REGION_CODE && word_idx < CODE_WORDS) begin
      return soc_mem_pkg::TGT_CODE;
    end
    if (addr[31:16] == soc_mem_pkg::REGION_DATA && word_idx < DATA_WORDS) begin
      return soc_mem_pkg::TGT_DATA;
    end
    return soc_mem_pkg::TGT_NONE;
  endfunction

  always_comb begin
    rd_tgt = decode_addr(s_req_i.araddr);
    wr_tgt = decode_addr(s_req_i.awaddr);
    err_ok = &ram_up_ff; // Error replies wait for both clear sweeps.

    // Payload goes to both RAMs, only the chosen one sees valid.
    code_req_o = s_req_i;
    data_req_o = s_req_i;
    code_req_o.arvalid = s_req_i.arvalid && !rd_pend_ff && (rd_tgt == soc_mem_pkg::TGT_CODE);
    data_req_o.arvalid = s_req_i.arvalid && !rd_pend_ff && (rd_tgt == soc_mem_pkg::TGT_DATA);
    code_req_o.awvalid = s_req_i.awvalid && !wr_pend_ff && (wr_tgt == soc_mem_pkg::TGT_CODE);
    data_req_o.awvalid = s_req_i.awvalid && !wr_pend_ff && (wr_tgt == soc_mem_pkg::TGT_DATA);
    code_req_o.wvalid  = s_req_i.wvalid && !wr_pend_ff && (wr_tgt == soc_mem_pkg::TGT_CODE);
    data_req_o.wvalid  = s_req_i.wvalid && !wr_pend_ff && (wr_tgt == soc_mem_pkg::TGT_DATA);
    code_req_o.rready  = s_req_i.rready && (rd_tgt_ff == soc_mem_pkg::TGT_CODE);
    data_req_o.rready  = s_req_i.rready && (rd_tgt_ff == soc_mem_pkg::TGT_DATA);
    code_req_o.bready  = s_req_i.bready && (wr_tgt_ff == soc_mem_pkg::TGT_CODE);
    data_req_o.bready  = s_req_i.bready && (wr_tgt_ff == soc_mem_pkg::TGT_DATA);

    ar_ready = 1'b0;
    if (!rd_pend_ff) begin
      case (rd_tgt)
        soc_mem_pkg::TGT_CODE: ar_ready = code_rsp_i.arready;
        soc_mem_pkg::TGT_DATA: ar_ready = data_rsp_i.arready;
        default:               ar_ready = err_ok;
      endcase
    end

    aw_ready = 1'b0;
    if (!wr_pend_ff) begin
      case (wr_tgt)
        soc_mem_pkg::TGT_CODE: aw_ready = code_rsp_i.awready;
        soc_mem_pkg::TGT_DATA: aw_ready = data_rsp_i.awready;
        default:               aw_ready = err_ok && s_req_i.awvalid && s_req_i.wvalid;
      endcase
    end

    s_rsp_o.arready = ar_ready;
    s_rsp_o.awready = aw_ready;
    s_rsp_o.wready  = aw_ready;

    // Responses follow the target recorded at the handshake.
    case (rd_tgt_ff)
      soc_mem_pkg::TGT_CODE: begin
        s_rsp_o.rvalid = code_rsp_i.rvalid;
        s_rsp_o.rdata  = code_rsp_i.rdata;
        s_rsp_o.rresp  = code_rsp_i.rresp;
      end
      soc_mem_pkg::TGT_DATA: begin
        s_rsp_o.rvalid = data_rsp_i.rvalid;
        s_rsp_o.rdata  = data_rsp_i.rdata;
        s_rsp_o.rresp  = data_rsp_i.rresp;
      end
      default: begin
        s_rsp_o.rvalid = rd_pend_ff; // Local DECERR one cycle after AR.
        s_rsp_o.rdata  = '0;
        s_rsp_o.rresp  = soc_mem_pkg::DECERR;
      end
    endcase

    case (wr_tgt_ff)
      soc_mem_pkg::TGT_CODE: begin
        s_rsp_o.bvalid = code_rsp_i.bvalid;
        s_rsp_o.bresp  = code_rsp_i.bresp;
      end
      soc_mem_pkg::TGT_DATA: begin
        s_rsp_o.bvalid = data_rsp_i.bvalid;
        s_rsp_o.bresp  = data_rsp_i.bresp;
      end
      default: begin
        s_rsp_o.bvalid = wr_pend_ff;
        s_rsp_o.bresp  = soc_mem_pkg::DECERR;
      end
    endcase
  end

  always_comb begin
    rd_hs   = s_req_i.arvalid && ar_ready;
    wr_hs   = s_req_i.awvalid && aw_ready;
    rd_done = s_rsp_o.rvalid && s_req_i.rready;
    wr_done = s_rsp_o.bvalid && s_req_i.bready;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_pend_ff <= 1'b0;
      wr_pend_ff <= 1'b0;
      rd_tgt_ff  <= soc_mem_pkg::TGT_NONE;
      wr_tgt_ff  <= soc_mem_pkg::TGT_NONE;
      ram_up_ff  <= '0;
    end else begin
      ram_up_ff <= ram_up_ff | {data_rsp_i.arready, code_rsp_i.arready}; // Sticky.
      if (rd_hs) begin
        rd_pend_ff <= 1'b1;
        rd_tgt_ff  <= rd_tgt;
      end else if (rd_done) begin
        rd_pend_ff <= 1'b0;
      end
      if (wr_hs) begin
        wr_pend_ff <= 1'b1;
        wr_tgt_ff  <= wr_tgt;
      end else if (wr_done) begin
        wr_pend_ff <= 1'b0;
      end
    end
  end

  a_one_ar_target: assert property (
    @(posedge clk) disable iff (!rst)
    !(code_req_o.arvalid && data_req_o.arvalid)
  );

  // A read response from either RAM blocks any new AR on the port.
  a_no_ar_while_r: assert property (
    @(posedge clk) disable iff (!rst)
    s_rsp_o.rvalid |-> !(s_req_i.arvalid && s_rsp_o.arready)
  );

endmodule

/* logic/irq_stim_gen.sv */
`timescale 1ns/1ps
// Interrupt stimulus generator.
// Three free-running counters drive the software, timer and external lines.
module irq_stim_gen (
  input  logic              clk,
  input  logic              rst,
  output soc_mem_pkg::irq_t irq_o
);
  logic [7:0] sw_cnt_ff;
  logic [7:0] timer_cnt_ff;
  logic [7:0] ext_cnt_ff;
  logic [7:0] next_sw;
  logic [7:0] next_timer;
  logic [7:0] next_ext;

  always_comb begin
    next_sw    = sw_cnt_ff + 8'd1;
    next_timer = timer_cnt_ff + 8'd2; // Runs twice as fast.
    next_ext   = ext_cnt_ff + 8'd1;

    irq_o.sw_irq    = sw_cnt_ff[4];    // Period of 32 cycles.
    irq_o.timer_irq = timer_cnt_ff[5]; // Period of 32 cycles, from 2n.
    irq_o.ext_irq   = ext_cnt_ff[6];   // Period of 128 cycles.
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      sw_cnt_ff    <= '0;
      timer_cnt_ff <= '0;
      ext_cnt_ff   <= '0;
    end else begin
      sw_cnt_ff    <= next_sw;
      timer_cnt_ff <= next_timer;
      ext_cnt_ff   <= next_ext;
    end
  end

endmodule

/* logic/mem_subsys_top.sv */
`timescale 1ns/1ps
// Memory subsystem top level.
// One AXI4-Lite target port routed to a code RAM and a data RAM,
// plus the interrupt stimulus generator.
module mem_subsys_top #(
  parameter int CODE_WORDS = 1024,
  parameter int DATA_WORDS = 2048
) (
  input  logic                   clk,
  input  logic                   rst,
  input  soc_mem_pkg::axil_req_t s_req_i,
  output soc_mem_pkg::axil_rsp_t s_rsp_o,
  output soc_mem_pkg::irq_t      irq_o
);
  soc_mem_pkg::axil_req_t code_req;
  soc_mem_pkg::axil_rsp_t code_rsp;
  soc_mem_pkg::axil_req_t data_req;
  soc_mem_pkg::axil_rsp_t data_rsp;

  axil_addr_router #(
    .CODE_WORDS (CODE_WORDS),
    .DATA_WORDS (DATA_WORDS)
  ) u_router (
    .clk        (clk),
    .rst        (rst),
    .s_req_i    (s_req_i),
    .s_rsp_o    (s_rsp_o),
    .code_req_o (code_req),
    .code_rsp_i (code_rsp),
    .data_req_o (data_req),
    .data_rsp_i (data_rsp)
  );

  axil_ram #(
    .MEM_WORDS (CODE_WORDS)
  ) u_code_ram (
    .clk   (clk),
    .rst   (rst),
    .req_i (code_req),
    .rsp_o (code_rsp)
  );

  axil_ram #(
    .MEM_WORDS (DATA_WORDS)
  ) u_data_ram (
    .clk   (clk),
    .rst   (rst),
    .req_i (data_req),
    .rsp_o (data_rsp)
  );

  irq_stim_gen u_irq_stim (
    .clk   (clk),
    .rst   (rst),
    .irq_o (irq_o)
  );

endmodule

/* sim/tb_mem_subsys.sv */
`timescale 1ns/1ps
// Testbench for the memory subsystem.
// Drives the AXI4-Lite port against a reference memory model and checks
// the interrupt stimulus lines after reset.
module tb_mem_subsys;
  localparam int CODE_WORDS  = 1024;
  localparam int DATA_WORDS  = 2048;
  localparam int NUM_RANDOM  = 200;
  localparam int NUM_TRANS   = 46 + NUM_RANDOM; // Directed tests plus the random mix.
  localparam int IRQ_CYCLES  = 300;
  localparam int CYCLE_LIMIT = 2048 + 20 * NUM_TRANS;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } rd_exp_t;

  logic                   clk = 1'b0;
  logic                   rst;
  soc_mem_pkg::axil_req_t s_req;
  soc_mem_pkg::axil_rsp_t s_rsp;
  soc_mem_pkg::irq_t      irq;

  logic [31:0] ref_mem [logic [31:0]]; // Keyed by word address.
  rd_exp_t     exp_r_q [$];
  logic [1:0]  exp_b_q [$];
  logic [31:0] lcg_state = 32'he091;
  int          cycle_cnt = 0;
  int          irq_n     = 0;

  mem_subsys_top #(
    .CODE_WORDS (CODE_WORDS),
    .DATA_WORDS (DATA_WORDS)
  ) u_mem_subsys_top (
    .clk     (clk),
    .rst     (rst),
    .s_req_i (s_req),
    .s_rsp_o (s_rsp),
    .irq_o   (irq)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] code_addr(int word);
    return {soc_mem_pkg::REGION_CODE, 14'(word), 2'b00};
  endfunction

  function automatic logic [31:0] data_addr(int word);
    return {soc_mem_pkg::REGION_DATA, 14'(word), 2'b00};
  endfunction

  function automatic logic is_mapped(logic [31:0] addr);
    int idx;
    idx = int'(addr[15:2]);
    return (addr[31:16] == soc_mem_pkg::REGION_CODE && idx < CODE_WORDS) ||
           (addr[31:16] == soc_mem_pkg::REGION_DATA && idx < DATA_WORDS);
  endfunction

  function automatic rd_exp_t ref_read(logic [31:0] addr);
    rd_exp_t r;
    r.data = '0;
    r.resp = soc_mem_pkg::DECERR; // Unmapped reads return zero data.
    if (is_mapped(addr)) begin
      r.resp = soc_mem_pkg::OKAY;
      if (ref_mem.exists({2'b00, addr[31:2]})) begin
        r.data = ref_mem[{2'b00, addr[31:2]}];
      end
    end
    return r;
  endfunction

  function automatic logic [1:0] ref_write(logic [31:0] addr, logic [31:0] data,
                                           logic [3:0] strb);
    rd_exp_t cur;
    if (!is_mapped(addr)) begin
      return soc_mem_pkg::DECERR;
    end
    cur = ref_read(addr);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        cur.data[8*b +: 8] = data[8*b +: 8];
      end
    end
    ref_mem[{2'b00, addr[31:2]}] = cur.data;
    return soc_mem_pkg::OKAY;
  endfunction

  function automatic soc_mem_pkg::irq_t irq_expect(int n);
    soc_mem_pkg::irq_t e;
    logic [7:0]        n1;
    logic [7:0]        n2;
    n1          = 8'(n);
    n2          = 8'(2 * n); // Timer counter steps by two.
    e.sw_irq    = n1[4];
    e.timer_irq = n2[5];
    e.ext_irq   = n1[6];
    return e;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on the first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic read_txn(input logic [31:0] addr);
    s_req.araddr  <= addr;
    s_req.arvalid <= 1'b1;
    s_req.rready  <= 1'b1;
    do @(posedge clk); while (!s_rsp.arready);
    exp_r_q.push_back(ref_read(addr));
    s_req.arvalid <= 1'b0;
    @(posedge clk);
    check_value("rvalid", s_rsp.rvalid, 1); // Exactly one cycle after AR.
  endtask

  task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    s_req.awaddr  <= addr;
    s_req.awvalid <= 1'b1;
    s_req.wdata   <= data;
    s_req.wstrb   <= strb;
    s_req.wvalid  <= 1'b1;
    s_req.bready  <= 1'b1;
    do @(posedge clk); while (!s_rsp.awready);
    check_value("wready", s_rsp.wready, 1); // W completes together with AW.
    exp_b_q.push_back(ref_write(addr, data, strb));
    s_req.awvalid <= 1'b0;
    s_req.wvalid  <= 1'b0;
    @(posedge clk);
    check_value("bvalid", s_rsp.bvalid, 1);
  endtask

  task automatic read_stall(input logic [31:0] addr1, input logic [31:0] addr2);
    int      hold;
    rd_exp_t exp1;
    hold = 1 + int'(rand_next() >> 28);
    s_req.araddr  <= addr1;
    s_req.arvalid <= 1'b1;
    s_req.rready  <= 1'b0;
    do @(posedge clk); while (!s_rsp.arready);
    exp1 = ref_read(addr1);
    exp_r_q.push_back(exp1);
    s_req.araddr <= addr2; // Second address waits behind the stalled response.
    @(posedge clk);
    repeat (hold) begin
      check_value("rvalid", s_rsp.rvalid, 1);
      check_value("rdata", s_rsp.rdata, exp1.data);
      check_value("arready", s_rsp.arready, 0);
      @(posedge clk);
    end
    read_txn(addr2);
  endtask

  task automatic write_stall(input logic [31:0] addr1, input logic [31:0] addr2);
    int          hold;
    logic [31:0] data1;
    logic [1:0]  exp1;
    hold  = 1 + int'(rand_next() >> 28);
    data1 = rand_next();
    s_req.awaddr  <= addr1;
    s_req.awvalid <= 1'b1;
    s_req.wdata   <= data1;
    s_req.wstrb   <= 4'hf;
    s_req.wvalid  <= 1'b1;
    s_req.bready  <= 1'b0;
    do @(posedge clk); while (!s_rsp.awready);
    exp1 = ref_write(addr1, data1, 4'hf);
    exp_b_q.push_back(exp1);
    s_req.awaddr <= addr2;
    @(posedge clk);
    repeat (hold) begin
      check_value("bvalid", s_rsp.bvalid, 1);
      check_value("bresp", {30'b0, s_rsp.bresp}, {30'b0, exp1});
      check_value("awready", s_rsp.awready, 0);
      check_value("wready", s_rsp.wready, 0);
      @(posedge clk);
    end
    write_txn(addr2, rand_next(), 4'hf);
  endtask

  // Every accepted response is compared in the cycle of its handshake.
  always @(posedge clk) begin : compare_resp
    rd_exp_t    exp_r;
    logic [1:0] exp_b;
    if (rst && s_rsp.rvalid && s_req.rready) begin
      if (exp_r_q.size() == 0) begin
        abort_run("A read response arrived with no read outstanding.");
      end else begin
        exp_r = exp_r_q.pop_front();
        check_value("rdata", s_rsp.rdata, exp_r.data);
        check_value("rresp", {30'b0, s_rsp.rresp}, {30'b0, exp_r.resp});
      end
    end
    if (rst && s_rsp.bvalid && s_req.bready) begin
      if (exp_b_q.size() == 0) begin
        abort_run("A write response arrived with no write outstanding.");
      end else begin
        exp_b = exp_b_q.pop_front();
        check_value("bresp", {30'b0, s_rsp.bresp}, {30'b0, exp_b});
      end
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      if (irq_n < IRQ_CYCLES) begin
        check_value("irq_o", {29'b0, irq}, {29'b0, irq_expect(irq_n)});
      end
      irq_n <= irq_n + 1; // Edges seen with reset released.
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      abort_run("Timeout: the run went past its cycle budget.");
    end
  end

  initial begin : main_seq
    logic [31:0] r;
    logic [31:0] addr;
    rst          = 1'b0;
    s_req        = '0;
    s_req.araddr = data_addr(0); // The data RAM has the longest clear sweep.
    @(posedge clk);
    repeat (2) begin
      @(posedge clk);
      check_value("rvalid", s_rsp.rvalid, 0);
      check_value("bvalid", s_rsp.bvalid, 0);
      check_value("arready", s_rsp.arready, 0);
    end
    rst <= 1'b1;
    do begin
      @(posedge clk);
      if (cycle_cnt > 2048 + 16) begin
        abort_run("arready did not rise after the reset clear sweep.");
      end
    end while (!s_rsp.arready);

    for (int i = 0; i < 4; i++) begin
      write_txn(code_addr(i * 37), rand_next(), 4'hf);
      write_txn(data_addr(2047 - i * 37), rand_next(), 4'hf);
      read_txn(code_addr(i * 37));
      read_txn(data_addr(2047 - i * 37));
    end

    for (int i = 0; i < 6; i++) begin
      addr = (i % 2 == 0) ? code_addr((i % 4) * 37) : data_addr(2047 - (i % 4) * 37);
      write_txn(addr, rand_next(), 4'(rand_next() >> 28));
      read_txn(addr);
    end

    write_txn(code_addr(0), 32'h1111_1111, 4'hf);
    write_txn(data_addr(0), 32'h2222_2222, 4'hf);
    write_txn(32'h1234_0000, 32'hdead_beef, 4'hf);
    write_txn(32'h1234_2000, 32'hdead_beef, 4'hf); // Would alias data word 0.
    write_txn(code_addr(1024), 32'hdead_beef, 4'hf);
    write_txn(data_addr(2048), 32'hdead_beef, 4'hf);
    read_txn(32'h1234_0000);
    read_txn(code_addr(1024));
    read_txn(code_addr(0));
    read_txn(data_addr(0));

    read_stall(code_addr(37), data_addr(2047));
    read_stall(data_addr(74), 32'h1234_0000);
    write_stall(code_addr(5), data_addr(6));
    write_stall(32'h1234_0010, code_addr(7));

    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = rand_next();
      case (r[31:30])
        2'd0:    addr = code_addr(int'(r[24:19]));
        2'd1:    addr = data_addr(int'(r[24:19]));
        2'd2:    addr = r[25] ? data_addr(2040 + int'(r[22:19])) : code_addr(1016 + int'(r[22:19]));
        default: addr = {r[23:8], 14'(r[24:19]), 2'b00};
      endcase
      if (r[29]) begin
        write_txn(addr, rand_next(), r[28:25]);
      end else begin
        read_txn(addr);
      end
    end

    repeat (2) @(posedge clk);
    if (exp_r_q.size() != 0 || exp_b_q.size() != 0) begin
      abort_run("Some responses never arrived before the end of the run.");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* sources.f */
logic/soc_mem_pkg.sv
logic/axil_ram.sv
logic/axil_addr_router.sv
logic/irq_stim_gen.sv
logic/mem_subsys_top.sv
sim/tb_mem_subsys.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  - logic/soc_mem_pkg.sv
  - logic/axil_ram.sv
  - logic/axil_addr_router.sv
  - logic/irq_stim_gen.sv
  - logic/mem_subsys_top.sv
  - target: simulation
    files:
      - sim/tb_mem_subsys.sv
